//--- common/emu_pkg.sv
`default_nettype none

package emu_pkg;

    // Register bus
    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    // Scan datapath
    localparam int WORD_W          = 64;
    localparam int CHAIN_FF_WORDS  = 4;
    localparam int CHAIN_MEM_WORDS = 3;
    localparam int RAM_WAIT_CYCLES = 2;
    localparam int BYTES_W         = 20;

    // Run control
    localparam int CYCLE_W = 64;

    // Sequencer counter covers the longest phase
    localparam int CNT_W = $clog2(CHAIN_FF_WORDS + CHAIN_MEM_WORDS + RAM_WAIT_CYCLES);

    typedef enum logic [ADDR_W-1:0] {
        REG_STAT      = 12'h000,
        REG_CYCLE_LO  = 12'h008,
        REG_CYCLE_HI  = 12'h00C,
        REG_STEP      = 12'h010,
        REG_SCAN_STAT = 12'h01C,
        REG_SCAN_CTRL = 12'h020
    } csr_addr_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_FF,
        PH_RAM_WAIT,
        PH_RAM
    } scan_phase_e;

    typedef struct packed {
        logic              en;
        csr_addr_e         addr;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic               halt;
        logic               dut_reset;
        logic [CYCLE_W-1:0] cycle;
        logic [DATA_W-1:0]  step;
    } run_stat_t;

    // dir set means scan-in
    typedef struct packed {
        logic               running;
        logic               dir;
        logic               start;
        logic [BYTES_W-1:0] bytes;
    } scan_stat_t;

endpackage

`default_nettype wire

//--- csr/emu_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module emu_axil_regs import emu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  logic [ADDR_W-1:0]   awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [DATA_W/8-1:0] wstrb,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    input  logic                arvalid,
    output logic                arready,
    input  logic [ADDR_W-1:0]   araddr,
    output logic                rvalid,
    input  logic                rready,
    output logic [DATA_W-1:0]   rdata,
    output logic [1:0]          rresp,
    input  run_stat_t           run_stat,
    input  scan_stat_t          scan_stat,
    output reg_wr_t             reg_wr
);

    logic [ADDR_W-1:0] aw_addr;
    logic [DATA_W-1:0] w_data;
    logic              aw_full;
    logic              w_full;
    logic              w_err;
    logic              b_err;
    logic              wr_fire;
    logic [ADDR_W-1:0] ar_addr;
    logic              ar_full;
    logic [DATA_W-1:0] rd_mux;

    // Address and data both held, previous response already taken
    assign wr_fire = aw_full && w_full && !bvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            w_err   <= 1'b0;
            b_err   <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_full <= 1'b1;
            end
            if (wvalid && wready) begin
                w_full <= 1'b1;
                w_err  <= (wstrb != '1);
            end
            if (wr_fire) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                b_err   <= w_err;
                bvalid  <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr <= awaddr;
        end
        if (wvalid && wready) begin
            w_data <= wdata;
        end
    end

    assign awready = !aw_full;
    assign wready  = !w_full;
    assign bresp   = b_err ? 2'b10 : 2'b00;

    // Partial strobes complete the handshake but write nothing
    always_comb begin
        reg_wr.en   = wr_fire && !w_err;
        reg_wr.addr = csr_addr_e'(aw_addr);
        reg_wr.data = w_data;
    end

    always_comb begin
        rd_mux = '0;
        case (csr_addr_e'(ar_addr))
            REG_STAT:      rd_mux = {{(DATA_W-2){1'b0}}, run_stat.dut_reset, run_stat.halt};
            REG_CYCLE_LO:  rd_mux = run_stat.cycle[DATA_W-1:0];
            REG_CYCLE_HI:  rd_mux = run_stat.cycle[CYCLE_W-1:DATA_W];
            REG_STEP:      rd_mux = run_stat.step;
            REG_SCAN_STAT: rd_mux = {scan_stat.bytes, {(DATA_W-BYTES_W-1){1'b0}},
                                     scan_stat.running};
            REG_SCAN_CTRL: rd_mux = {{(DATA_W-2){1'b0}}, scan_stat.dir, scan_stat.start};
            default:       rd_mux = '0;
        endcase
    end

    // Address latched on the handshake, data one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_full <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_full <= 1'b1;
            end
            if (ar_full && !rvalid) begin
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                ar_full <= 1'b0;
                rvalid  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_addr <= araddr;
        end
        if (ar_full && !rvalid) begin
            rdata <= rd_mux;
        end
    end

    assign arready = !ar_full;
    assign rresp   = 2'b00;

endmodule

`default_nettype wire

//--- rtl/emu_run_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module emu_run_ctrl import emu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_wr_t   reg_wr,
    input  logic      dut_trig,
    output run_stat_t run_stat,
    output logic      dut_halt,
    output logic      dut_reset
);

    logic [CYCLE_W-1:0] cycle;
    logic [DATA_W-1:0]  step;
    logic               step_end;

    // Last running cycle of a step count
    assign step_end = !dut_halt && (step == DATA_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            dut_halt  <= 1'b1;
            dut_reset <= 1'b1;
        end else begin
            if (reg_wr.en && reg_wr.addr == REG_STAT) begin
                dut_halt  <= reg_wr.data[0];
                dut_reset <= reg_wr.data[1];
            end
            // Trigger and step end override a halt release
            if (dut_trig || step_end) begin
                dut_halt <= 1'b1;
            end
        end
    end

    // Halves are writable only while halted
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!dut_halt) begin
            cycle <= cycle + 1'b1;
        end else begin
            if (reg_wr.en && reg_wr.addr == REG_CYCLE_LO) begin
                cycle[DATA_W-1:0] <= reg_wr.data;
            end
            if (reg_wr.en && reg_wr.addr == REG_CYCLE_HI) begin
                cycle[CYCLE_W-1:DATA_W] <= reg_wr.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (reg_wr.en && reg_wr.addr == REG_STEP) begin
            step <= reg_wr.data;
        end else if (!dut_halt && step != '0) begin
            step <= step - 1'b1;
        end
    end

    always_comb begin
        run_stat.halt      = dut_halt;
        run_stat.dut_reset = dut_reset;
        run_stat.cycle     = cycle;
        run_stat.step      = step;
    end

endmodule

`default_nettype wire

//--- rtl/emu_scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module emu_scan_ctrl import emu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  reg_wr_t           reg_wr,
    input  logic              so_ready,
    input  logic              si_valid,
    input  logic [WORD_W-1:0] si_data,
    input  logic [WORD_W-1:0] ff_sdo,
    input  logic [WORD_W-1:0] ram_sdo,
    output scan_stat_t        scan_stat,
    output logic              so_valid,
    output logic              so_last,
    output logic [WORD_W-1:0] so_data,
    output logic              si_ready,
    output logic              dut_clk_en,
    output logic              ff_scan,
    output logic [WORD_W-1:0] ff_sdi,
    output logic              ram_scan,
    output logic              ram_dir,
    output logic [WORD_W-1:0] ram_sdi
);

    scan_phase_e        phase;
    logic               running;
    logic               dir;
    logic               start;
    logic [CNT_W-1:0]   cnt;
    logic [BYTES_W-1:0] bytes;
    logic               start_wr;
    logic               stall;
    logic               adv;
    logic               word_ph;
    logic               cnt_end;

    // A new request is ignored while a scan is in flight
    assign start_wr = reg_wr.en && reg_wr.addr == REG_SCAN_CTRL && !running;

    // Stream side not ready, so DUT and sequencer hold
    assign stall      = running && (dir ? !si_valid : !so_ready);
    assign dut_clk_en = !stall;
    assign adv        = running && !stall;

    assign word_ph = (phase == PH_FF) || (phase == PH_RAM);

    always_comb begin
        case (phase)
            PH_FF:       cnt_end = (cnt == CNT_W'(CHAIN_FF_WORDS - 1));
            PH_RAM_WAIT: cnt_end = (cnt == CNT_W'(RAM_WAIT_CYCLES - 1));
            PH_RAM:      cnt_end = (cnt == CNT_W'(CHAIN_MEM_WORDS - 1));
            default:     cnt_end = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= PH_IDLE;
            running <= 1'b0;
            dir     <= 1'b0;
            start   <= 1'b0;
            cnt     <= '0;
            bytes   <= '0;
        end else begin
            start <= 1'b0;
            if (start_wr) begin
                dir     <= reg_wr.data[1];
                start   <= reg_wr.data[0];
                running <= reg_wr.data[0];
                if (reg_wr.data[0]) begin
                    phase <= PH_FF;
                    bytes <= '0;
                end
            end else if (adv) begin
                if (word_ph) begin
                    bytes <= bytes + BYTES_W'(WORD_W / 8);
                end
                if (cnt_end) begin
                    cnt <= '0;
                    case (phase)
                        // Scan-in goes straight to the memory chain
                        PH_FF:       phase <= dir ? PH_RAM : PH_RAM_WAIT;
                        PH_RAM_WAIT: phase <= PH_RAM;
                        default: begin
                            phase   <= PH_IDLE;
                            running <= 1'b0;
                        end
                    endcase
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    assign so_valid = !dir && word_ph;
    assign so_last  = !dir && (phase == PH_RAM) && cnt_end;
    assign si_ready = dir && word_ph;

    assign ff_scan  = (phase == PH_FF);
    assign ram_scan = (phase == PH_RAM);
    assign ram_dir  = dir;

    // Scan-out recirculates the chain so its contents survive
    assign ff_sdi  = dir ? si_data : ff_sdo;
    assign ram_sdi = si_data;
    assign so_data = (phase == PH_RAM) ? ram_sdo : ff_sdo;

    always_comb begin
        scan_stat.running = running;
        scan_stat.dir     = dir;
        scan_stat.start   = start;
        scan_stat.bytes   = bytes;
    end

endmodule

`default_nettype wire

//--- rtl/emu_system.sv
`timescale 1ns/1ps
`default_nettype none

module emu_system import emu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  logic [ADDR_W-1:0]   awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [DATA_W/8-1:0] wstrb,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    input  logic                arvalid,
    output logic                arready,
    input  logic [ADDR_W-1:0]   araddr,
    output logic                rvalid,
    input  logic                rready,
    output logic [DATA_W-1:0]   rdata,
    output logic [1:0]          rresp,
    output logic [WORD_W-1:0]   so_data,
    output logic                so_valid,
    input  logic                so_ready,
    output logic                so_last,
    input  logic [WORD_W-1:0]   si_data,
    input  logic                si_valid,
    output logic                si_ready,
    output logic                dut_clk_en,
    output logic                dut_halt,
    output logic                dut_reset,
    input  logic                dut_trig,
    output logic                ff_scan,
    output logic [WORD_W-1:0]   ff_sdi,
    input  logic [WORD_W-1:0]   ff_sdo,
    output logic                ram_scan,
    output logic                ram_dir,
    output logic [WORD_W-1:0]   ram_sdi,
    input  logic [WORD_W-1:0]   ram_sdo
);

    reg_wr_t    reg_wr;
    run_stat_t  run_stat;
    scan_stat_t scan_stat;

    emu_axil_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .run_stat  (run_stat),
        .scan_stat (scan_stat),
        .reg_wr    (reg_wr)
    );

    emu_run_ctrl u_run (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .dut_trig  (dut_trig),
        .run_stat  (run_stat),
        .dut_halt  (dut_halt),
        .dut_reset (dut_reset)
    );

    emu_scan_ctrl u_scan (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .so_ready   (so_ready),
        .si_valid   (si_valid),
        .si_data    (si_data),
        .ff_sdo     (ff_sdo),
        .ram_sdo    (ram_sdo),
        .scan_stat  (scan_stat),
        .so_valid   (so_valid),
        .so_last    (so_last),
        .so_data    (so_data),
        .si_ready   (si_ready),
        .dut_clk_en (dut_clk_en),
        .ff_scan    (ff_scan),
        .ff_sdi     (ff_sdi),
        .ram_scan   (ram_scan),
        .ram_dir    (ram_dir),
        .ram_sdi    (ram_sdi)
    );

endmodule

`default_nettype wire

//--- test/emu_system_sva.sv
`timescale 1ns/1ps
`default_nettype none

module emu_system_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic so_valid,
    input wire logic so_ready,
    input wire logic so_last,
    input wire logic ff_scan,
    input wire logic ram_scan,
    input wire logic dut_clk_en
);

    a_last_with_valid: assert property (@(posedge clk) disable iff (rst)
        so_last |-> so_valid)
        else $error("so_last without so_valid");

    // Offered word stays until taken
    a_valid_holds: assert property (@(posedge clk) disable iff (rst)
        so_valid && !so_ready |=> so_valid)
        else $error("so_valid dropped before so_ready");

    // A stalled cycle keeps the sequencer on the same chain
    a_chain_holds: assert property (@(posedge clk) disable iff (rst)
        (ff_scan || ram_scan) && !dut_clk_en |=> $stable({ff_scan, ram_scan}))
        else $error("scan chain changed on a stalled cycle");

endmodule

bind emu_scan_ctrl emu_system_sva sva_i (
    .clk        (clk),
    .rst        (rst),
    .so_valid   (so_valid),
    .so_ready   (so_ready),
    .so_last    (so_last),
    .ff_scan    (ff_scan),
    .ram_scan   (ram_scan),
    .dut_clk_en (dut_clk_en)
);

`default_nettype wire

//--- test/emu_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module emu_system_tb import emu_pkg::*; ();

    localparam int N_WORDS = CHAIN_FF_WORDS + CHAIN_MEM_WORDS;
    localparam int TIMEOUT = 1000;
    localparam int MA_W    = $clog2(CHAIN_MEM_WORDS);

    logic                clk = 1'b0;
    logic                rst;
    logic                awvalid;
    logic                awready;
    logic [ADDR_W-1:0]   awaddr;
    logic                wvalid;
    logic                wready;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                bvalid;
    logic                bready;
    logic [1:0]          bresp;
    logic                arvalid;
    logic                arready;
    logic [ADDR_W-1:0]   araddr;
    logic                rvalid;
    logic                rready;
    logic [DATA_W-1:0]   rdata;
    logic [1:0]          rresp;
    logic [WORD_W-1:0]   so_data;
    logic                so_valid;
    logic                so_ready;
    logic                so_last;
    logic [WORD_W-1:0]   si_data;
    logic                si_valid;
    logic                si_ready;
    logic                dut_clk_en;
    logic                dut_halt;
    logic                dut_reset;
    logic                dut_trig;
    logic                ff_scan;
    logic [WORD_W-1:0]   ff_sdi;
    logic [WORD_W-1:0]   ff_sdo;
    logic                ram_scan;
    logic                ram_dir;
    logic [WORD_W-1:0]   ram_sdi;
    logic [WORD_W-1:0]   ram_sdo;

    // Emulated DUT state
    logic [WORD_W-1:0] ff_chain [CHAIN_FF_WORDS];
    logic [WORD_W-1:0] mem [CHAIN_MEM_WORDS];
    logic [WORD_W-1:0] ff_init [CHAIN_FF_WORDS];
    logic [WORD_W-1:0] mem_init [CHAIN_MEM_WORDS];
    logic [MA_W-1:0]   ram_addr;

    logic [WORD_W-1:0] exp_q [$];
    logic [WORD_W-1:0] sent [N_WORDS];
    int                out_cnt = 0;
    int                in_cnt = 0;
    int                seed = 32'h04d0_199f;

    always #10 clk = ~clk;

    emu_system dut_i (
        .clk (clk), .rst (rst),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .so_data (so_data), .so_valid (so_valid), .so_ready (so_ready), .so_last (so_last),
        .si_data (si_data), .si_valid (si_valid), .si_ready (si_ready),
        .dut_clk_en (dut_clk_en), .dut_halt (dut_halt), .dut_reset (dut_reset),
        .dut_trig (dut_trig),
        .ff_scan (ff_scan), .ff_sdi (ff_sdi), .ff_sdo (ff_sdo),
        .ram_scan (ram_scan), .ram_dir (ram_dir), .ram_sdi (ram_sdi), .ram_sdo (ram_sdo)
    );

    // Chain tail feeds ff_sdo and memory is read at the scan address
    assign ff_sdo  = ff_chain[CHAIN_FF_WORDS-1];
    assign ram_sdo = mem[ram_addr];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CHAIN_FF_WORDS; i++) begin
                ff_chain[i] <= ff_init[i];
            end
            for (int i = 0; i < CHAIN_MEM_WORDS; i++) begin
                mem[i] <= mem_init[i];
            end
            ram_addr <= '0;
        end else begin
            if (dut_clk_en && ff_scan) begin
                ff_chain[0] <= ff_sdi;
                for (int i = 1; i < CHAIN_FF_WORDS; i++) begin
                    ff_chain[i] <= ff_chain[i-1];
                end
            end
            if (!ram_scan) begin
                ram_addr <= '0;
            end else if (dut_clk_en) begin
                if (ram_dir) begin
                    mem[ram_addr] <= ram_sdi;
                end
                ram_addr <= ram_addr + 1'b1;
            end
        end
    end

    // Stream order is the FF tail first and then memory from address 0
    function automatic logic [WORD_W-1:0] ref_word(input int pos);
        if (pos < CHAIN_FF_WORDS) begin
            return ff_chain[CHAIN_FF_WORDS-1-pos];
        end
        return mem[pos-CHAIN_FF_WORDS];
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: timed out waiting for %s at %0t", what, $time);
        abort_run();
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic write_reg(input csr_addr_e addr, input logic [DATA_W-1:0] data,
                             input logic [DATA_W/8-1:0] strb, output logic [1:0] resp);
        int   t;
        logic aw_done;
        logic w_done;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        t = 0;
        while (awvalid || wvalid) begin
            // Ready seen mid-cycle means the transfer lands on the next edge
            aw_done = awvalid && awready;
            w_done  = wvalid && wready;
            @(negedge clk);
            if (aw_done) begin
                awvalid = 1'b0;
            end
            if (w_done) begin
                wvalid = 1'b0;
            end
            t++;
            if (t > TIMEOUT) begin
                report_timeout("awready and wready");
            end
        end
        bready = 1'b1;
        t = 0;
        while (!bvalid) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                report_timeout("bvalid");
            end
        end
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input csr_addr_e addr, output logic [DATA_W-1:0] data);
        int t;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        t = 0;
        while (!arready) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                report_timeout("arready");
            end
        end
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        t = 0;
        while (!rvalid) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                report_timeout("rvalid");
            end
        end
        data = rdata;
        check_resp(rresp, 2'b00, "rresp");
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Compares each scan-out word as it is taken
    always @(posedge clk) begin
        logic [WORD_W-1:0] exp;
        if (!rst && so_valid && so_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: scan-out word beyond the chain length at %0t", $time);
                abort_run();
            end
            exp = exp_q.pop_front();
            check_word(so_data, exp, "so_data");
            check_data(DATA_W'(so_last), DATA_W'(exp_q.size() == 0), "so_last");
            out_cnt <= out_cnt + 1;
        end
        if (!rst && si_valid && si_ready) begin
            in_cnt <= in_cnt + 1;
        end
    end

    initial begin
        logic [DATA_W-1:0] rd;
        logic [1:0]        resp;
        int                t;
        int                r;
        rst      = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        so_ready = 1'b0;
        si_valid = 1'b0;
        si_data  = '0;
        dut_trig = 1'b0;
        for (int i = 0; i < CHAIN_FF_WORDS; i++) begin
            ff_init[i] = {$random(seed), $random(seed)};
        end
        for (int i = 0; i < CHAIN_MEM_WORDS; i++) begin
            mem_init[i] = {$random(seed), $random(seed)};
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;

        read_reg(REG_STAT, rd);
        check_data(rd, 32'h3, "STAT after reset");
        check_data(DATA_W'({dut_reset, dut_halt}), 32'h3, "DUT reset and halt pins after reset");
        read_reg(REG_SCAN_STAT, rd);
        check_data(rd, 32'h0, "SCAN_STAT after reset");

        // Partial strobe is rejected
        write_reg(REG_STEP, 32'h0000_1234, 4'b0011, resp);
        check_resp(resp, 2'b10, "bresp on partial strobe");
        read_reg(REG_STEP, rd);
        check_data(rd, 32'h0, "STEP after partial strobe");

        // Five stepped cycles from a preloaded count
        write_reg(REG_CYCLE_LO, 32'd100, 4'hF, resp);
        check_resp(resp, 2'b00, "bresp CYCLE_LO");
        write_reg(REG_STEP, 32'd5, 4'hF, resp);
        check_resp(resp, 2'b00, "bresp STEP");
        write_reg(REG_STAT, 32'h0, 4'hF, resp);
        check_resp(resp, 2'b00, "bresp STAT");
        read_reg(REG_STAT, rd);
        t = 0;
        while (rd[0] == 1'b0) begin
            t++;
            if (t > TIMEOUT) begin
                report_timeout("halt after step");
            end
            read_reg(REG_STAT, rd);
        end
        check_data(rd, 32'h1, "STAT after step");
        check_data(DATA_W'({dut_reset, dut_halt}), 32'h1, "DUT reset and halt pins after step");
        read_reg(REG_CYCLE_LO, rd);
        check_data(rd, 32'd105, "CYCLE_LO after step");

        // Free run until the trigger halts it
        write_reg(REG_STAT, 32'h0, 4'hF, resp);
        check_resp(resp, 2'b00, "bresp STAT");
        read_reg(REG_STAT, rd);
        check_data(rd, 32'h0, "STAT while running");
        check_data(DATA_W'({dut_reset, dut_halt}), 32'h0, "DUT reset and halt pins running");
        @(negedge clk);
        dut_trig = 1'b1;
        @(negedge clk);
        dut_trig = 1'b0;
        read_reg(REG_STAT, rd);
        check_data(rd, 32'h1, "STAT after trigger");
        check_data(DATA_W'({dut_reset, dut_halt}), 32'h1, "DUT reset and halt pins after trigger");

        // Scan-out under random back-pressure
        for (int p = 0; p < N_WORDS; p++) begin
            exp_q.push_back(ref_word(p));
        end
        write_reg(REG_SCAN_CTRL, 32'h1, 4'hF, resp);
        check_resp(resp, 2'b00, "bresp scan-out start");
        t = 0;
        while (out_cnt < N_WORDS) begin
            @(negedge clk);
            r = $random(seed);
            so_ready = r[0];
            t++;
            if (t > TIMEOUT) begin
                report_timeout("scan-out words");
            end
        end
        @(negedge clk);
        so_ready = 1'b0;
        read_reg(REG_SCAN_STAT, rd);
        check_data(rd, 32'(8 * N_WORDS) << 12, "SCAN_STAT after scan-out");
        // Scan-out feeds each word back into the chain head
        for (int p = 0; p < CHAIN_FF_WORDS; p++) begin
            check_word(ff_chain[p], ff_init[p], $sformatf("FF word %0d after scan-out", p));
        end

        // Scan-in with random gaps on the incoming stream
        for (int p = 0; p < N_WORDS; p++) begin
            sent[p] = {$random(seed), $random(seed)};
        end
        write_reg(REG_SCAN_CTRL, 32'h3, 4'hF, resp);
        check_resp(resp, 2'b00, "bresp scan-in start");
        t = 0;
        while (in_cnt < N_WORDS) begin
            @(negedge clk);
            r = $random(seed);
            si_valid = r[0] && (in_cnt < N_WORDS);
            if (in_cnt < N_WORDS) begin
                si_data = sent[in_cnt];
            end
            t++;
            if (t > TIMEOUT) begin
                report_timeout("scan-in words");
            end
        end
        @(negedge clk);
        si_valid = 1'b0;
        read_reg(REG_SCAN_STAT, rd);
        check_data(rd, 32'(8 * N_WORDS) << 12, "SCAN_STAT after scan-in");
        for (int p = 0; p < N_WORDS; p++) begin
            check_word(ref_word(p), sent[p], $sformatf("chain word %0d", p));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- emu_system.f
common/emu_pkg.sv
csr/emu_axil_regs.sv
rtl/emu_run_ctrl.sv
rtl/emu_scan_ctrl.sv
rtl/emu_system.sv
test/emu_system_sva.sv
test/emu_system_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= emu_system_tb
FILELIST  ?= emu_system.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
